// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
TOP       ?= thorExecUnitTb
FILELIST  ?= compile.f
BUILD     ?= obj_dir
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The run passes only when the testbench prints the pass line
run: build
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

// ==== bench/thorExecUnitTb.sv ====
// Testbench for the Thor execution slice, driving the AXI4-Lite host port against a register model
`timescale 1ns/1ps
`include "thorCore_params.svh"

module thorExecUnitTb;

	localparam int timeoutCycles = 4000;
	localparam logic [31:0] seed = 32'hae6effc7;
	localparam logic [6:0] regOps [6] = '{thorIsaPkg::OP_ADD, thorIsaPkg::OP_SUB,
		thorIsaPkg::OP_AND, thorIsaPkg::OP_OR, thorIsaPkg::OP_EOR, thorIsaPkg::OP_SLT};
	localparam logic [6:0] immOps [6] = '{thorIsaPkg::OP_ADDI, thorIsaPkg::OP_SUBFI,
		thorIsaPkg::OP_ANDI, thorIsaPkg::OP_ORI, thorIsaPkg::OP_EORI, thorIsaPkg::OP_SLTI};

	logic                  clk;
	logic                  rst;
	thorBusPkg::axiReq_t   req;
	thorBusPkg::axiRsp_t   rsp;
	// Reference register file and counters, advanced one instruction at a time
	logic [`THOR_XLEN-1:0] refRegs [`THOR_NREGS];
	int                    refRetired;
	int                    refIllegal;
	int                    errorCount;
	int                    testErrors;
	int                    testCount;
	int                    failedTests;
	int                    cycleCount;
	int                    ackCount;
	bit                    randomReady;
	logic [31:0]           burstQ [$];

	thorExecUnit thorExecUnit_i
	(
		.clk (clk),
		.rst (rst),
		.req (req),
		.rsp (rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Whole run is bounded, a stuck handshake ends here
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == timeoutCycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", timeoutCycles);
			$display("tests failed");
			$finish;
		end
	end

	// ==========================================================================
	// Host port protocol checks
	// ==========================================================================

	// A response that the host has not taken stays put
	bHold: assert property (@(posedge clk) disable iff (rst)
		rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
	else
	begin
		$display("[ERROR] %0t: bvalid or bresp changed before bready", $time);
		errorCount++;
	end

	rHold: assert property (@(posedge clk) disable iff (rst)
		rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata) && $stable(rsp.rresp))
	else
	begin
		$display("[ERROR] %0t: rvalid, rdata or rresp changed before rready", $time);
		errorCount++;
	end

	// Responses only follow an accepted request
	bAfterAw: assert property (@(posedge clk) disable iff (rst)
		$rose(rsp.bvalid) |-> $past(rsp.awready))
	else
	begin
		$display("[ERROR] %0t: bvalid rose without a write handshake", $time);
		errorCount++;
	end

	rAfterAr: assert property (@(posedge clk) disable iff (rst)
		$rose(rsp.rvalid) |-> $past(rsp.arready))
	else
	begin
		$display("[ERROR] %0t: rvalid rose without a read handshake", $time);
		errorCount++;
	end

	// Address and data channels are accepted together and only when both are offered
	awWithW: assert property (@(posedge clk) disable iff (rst)
		(rsp.awready == rsp.wready) && (!rsp.awready || (req.awvalid && req.wvalid)))
	else
	begin
		$display("[ERROR] %0t: awready and wready out of step with the request", $time);
		errorCount++;
	end

	// ==========================================================================
	// Instruction encoding and reference model
	// ==========================================================================

	function automatic logic [31:0] rWord(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] ra, input logic [4:0] rb);
		return {10'b0, rb, ra, rd, op};
	endfunction

	function automatic logic [31:0] iWord(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] ra, input logic [14:0] imm);
		return {imm, ra, rd, op};
	endfunction

	function automatic logic [11:0] regAddr(input int idx);
		return `THOR_ADDR_REGBASE + 12'(4 * idx);
	endfunction

	// Executes one word in program order on the reference state
	function automatic void modelIssue(input logic [31:0] w);
		logic [6:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] r;
		logic        ok;
		op  = w[6:0];
		a   = refRegs[w[16:12]];
		b   = refRegs[w[21:17]];
		imm = {{17{w[31]}}, w[31:17]};
		r   = '0;
		ok  = 1'b1;
		case (op)
		thorIsaPkg::OP_ADD:   r = a + b;
		thorIsaPkg::OP_ADDI:  r = a + imm;
		thorIsaPkg::OP_SUB:   r = a - b;
		// Immediate minus register
		thorIsaPkg::OP_SUBFI: r = imm - a;
		thorIsaPkg::OP_AND:   r = a & b;
		thorIsaPkg::OP_ANDI:  r = a & imm;
		thorIsaPkg::OP_OR:    r = a | b;
		thorIsaPkg::OP_ORI:   r = a | imm;
		thorIsaPkg::OP_EOR:   r = a ^ b;
		thorIsaPkg::OP_EORI:  r = a ^ imm;
		thorIsaPkg::OP_SLT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		thorIsaPkg::OP_SLTI:  r = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
		default:              ok = 1'b0;
		endcase
		refRetired++;
		if (!ok)
			refIllegal++;
		else if (w[11:7] != 5'd0)
			refRegs[w[11:7]] = r;
	endfunction

	// ==========================================================================
	// AXI4-Lite host tasks
	// ==========================================================================

	// Single write; with randomReady set, bready comes a few cycles late
	task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int gap;
		gap = randomReady ? int'($urandom_range(4, 1)) : 0;
		@(posedge clk);
		req.awvalid <= 1'b1;
		req.awaddr  <= addr;
		req.wvalid  <= 1'b1;
		req.wdata   <= data;
		req.wstrb   <= 4'hF;
		req.bready  <= (gap == 0);
		@(negedge clk);
		while (!rsp.awready)
			@(negedge clk);
		@(posedge clk);
		req.awvalid <= 1'b0;
		req.wvalid  <= 1'b0;
		if (gap != 0)
		begin
			repeat (gap) @(posedge clk);
			req.bready <= 1'b1;
		end
		@(negedge clk);
		while (!rsp.bvalid)
			@(negedge clk);
		resp = rsp.bresp;
		@(posedge clk);
		req.bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [11:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int gap;
		gap = randomReady ? int'($urandom_range(4, 1)) : 0;
		@(posedge clk);
		req.arvalid <= 1'b1;
		req.araddr  <= addr;
		req.rready  <= (gap == 0);
		@(negedge clk);
		while (!rsp.arready)
			@(negedge clk);
		@(posedge clk);
		req.arvalid <= 1'b0;
		if (gap != 0)
		begin
			repeat (gap) @(posedge clk);
			req.rready <= 1'b1;
		end
		@(negedge clk);
		while (!rsp.rvalid)
			@(negedge clk);
		data = rsp.rdata;
		resp = rsp.rresp;
		@(posedge clk);
		req.rready <= 1'b0;
	endtask

	// Counts one write response seen mid-cycle during a burst
	task automatic noteAck();
		if (rsp.bvalid)
		begin
			ackCount++;
			assert (rsp.bresp == thorBusPkg::RESP_OKAY)
			else
			begin
				$display("[ERROR] %0t: burst write answered with bresp %0d", $time, rsp.bresp);
				errorCount++;
			end
		end
	endtask

	// Issues burstQ at the slave's full rate so neighbours depend through forwarding
	task automatic issueBurst();
		int idx;
		ackCount = 0;
		@(posedge clk);
		req.bready <= 1'b1;
		for (idx = 0; idx < burstQ.size(); idx++)
		begin
			req.awvalid <= 1'b1;
			req.awaddr  <= `THOR_ADDR_INSTR;
			req.wvalid  <= 1'b1;
			req.wdata   <= burstQ[idx];
			req.wstrb   <= 4'hF;
			modelIssue(burstQ[idx]);
			@(negedge clk);
			noteAck();
			while (!rsp.awready)
			begin
				@(negedge clk);
				noteAck();
			end
			@(posedge clk);
		end
		req.awvalid <= 1'b0;
		req.wvalid  <= 1'b0;
		while (ackCount < burstQ.size())
		begin
			@(negedge clk);
			noteAck();
		end
		@(posedge clk);
		req.bready <= 1'b0;
		burstQ.delete();
	endtask

	task automatic writeInstr(input logic [31:0] word);
		logic [1:0] resp;
		axiWrite(`THOR_ADDR_INSTR, word, resp);
		modelIssue(word);
		assert (resp == thorBusPkg::RESP_OKAY)
		else
		begin
			$display("[ERROR] %0t: instruction write answered with bresp %0d", $time, resp);
			errorCount++;
		end
	endtask

	task automatic expectWriteError(input logic [11:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axiWrite(addr, data, resp);
		assert (resp == thorBusPkg::RESP_SLVERR)
		else
		begin
			$display("[ERROR] %0t: write to 0x%03h gave bresp %0d, expected SLVERR",
				$time, addr, resp);
			errorCount++;
		end
	endtask

	task automatic checkRead(input logic [11:0] addr, input logic [31:0] expData,
		input logic [1:0] expResp);
		logic [31:0] data;
		logic [1:0]  resp;
		axiRead(addr, data, resp);
		assert (data == expData && resp == expResp)
		else
		begin
			$display("[ERROR] %0t: read 0x%03h gave %08h resp %0d, expected %08h resp %0d",
				$time, addr, data, resp, expData, expResp);
			errorCount++;
		end
	endtask

	task automatic checkReg(input int idx);
		checkRead(regAddr(idx), refRegs[idx], thorBusPkg::RESP_OKAY);
	endtask

	// Illegal count sits above the retired count
	task automatic checkStatus();
		checkRead(`THOR_ADDR_STATUS, {refIllegal[15:0], refRetired[15:0]},
			thorBusPkg::RESP_OKAY);
	endtask

	// Builds a wide value in a register from a sign-extended addi and an ori
	task automatic queueLoad(input logic [4:0] idx);
		burstQ.push_back(iWord(thorIsaPkg::OP_ADDI, idx, 5'd0, 15'($urandom)));
		burstQ.push_back(iWord(thorIsaPkg::OP_ORI, idx, idx, 15'($urandom)));
	endtask

	// ==========================================================================
	// Tests
	// ==========================================================================

	task automatic resetChecks();
		int i;
		repeat (3)
		begin
			@(negedge clk);
			assert (!rsp.bvalid && !rsp.rvalid && !rsp.awready && !rsp.arready)
			else
			begin
				$display("[ERROR] %0t: host port active with no request", $time);
				errorCount++;
			end
		end
		checkStatus();
		for (i = 0; i < `THOR_NREGS; i++)
			checkReg(i);
	endtask

	task automatic registerOps();
		int         opIdx;
		int         round;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rd;
		for (opIdx = 0; opIdx < 6; opIdx++)
		begin
			for (round = 0; round < 2; round++)
			begin
				ra = 5'(1 + $urandom_range(30, 0));
				rb = 5'(1 + $urandom_range(30, 0));
				rd = 5'(1 + $urandom_range(30, 0));
				queueLoad(ra);
				queueLoad(rb);
				burstQ.push_back(rWord(regOps[opIdx], rd, ra, rb));
				issueBurst();
				checkReg(rd);
			end
		end
	endtask

	// Every immediate form with a positive and a negative field
	task automatic immediateOps();
		int         opIdx;
		int         neg;
		logic [4:0] ra;
		logic [4:0] rd;
		for (opIdx = 0; opIdx < 6; opIdx++)
		begin
			for (neg = 0; neg < 2; neg++)
			begin
				ra = 5'(1 + $urandom_range(30, 0));
				rd = 5'(1 + $urandom_range(30, 0));
				queueLoad(ra);
				issueBurst();
				writeInstr(iWord(immOps[opIdx], rd, ra, {neg[0], 14'($urandom)}));
				checkReg(rd);
			end
		end
	endtask

	task automatic dependentChain();
		int i;
		burstQ.push_back(iWord(thorIsaPkg::OP_ADDI, 5'd5, 5'd0, 15'h1234));
		burstQ.push_back(rWord(thorIsaPkg::OP_ADD, 5'd6, 5'd5, 5'd5));
		burstQ.push_back(rWord(thorIsaPkg::OP_SUB, 5'd7, 5'd6, 5'd5));
		burstQ.push_back(rWord(thorIsaPkg::OP_EOR, 5'd5, 5'd7, 5'd6));
		burstQ.push_back(rWord(thorIsaPkg::OP_SLT, 5'd8, 5'd5, 5'd7));
		// Result aimed at r0 must never reach a later reader of r0
		burstQ.push_back(iWord(thorIsaPkg::OP_ADDI, 5'd0, 5'd5, 15'h0007));
		burstQ.push_back(rWord(thorIsaPkg::OP_OR, 5'd9, 5'd0, 5'd5));
		burstQ.push_back(iWord(thorIsaPkg::OP_SUBFI, 5'd10, 5'd9, 15'h7FFD));
		burstQ.push_back(iWord(thorIsaPkg::OP_ANDI, 5'd11, 5'd10, 15'h7FF0));
		burstQ.push_back(rWord(thorIsaPkg::OP_ADD, 5'd12, 5'd11, 5'd8));
		issueBurst();
		for (i = 5; i <= 12; i++)
			checkReg(i);
		checkReg(0);
	endtask

	task automatic illegalOps();
		writeInstr(iWord(thorIsaPkg::OP_ADDI, 5'd13, 5'd0, 15'h1357));
		burstQ.push_back(rWord(7'h00, 5'd13, 5'd13, 5'd13));
		burstQ.push_back(rWord(7'h7F, 5'd13, 5'd13, 5'd13));
		burstQ.push_back(rWord(7'h20, 5'd13, 5'd13, 5'd13));
		// Load is known to the immediate detector but still not executed
		burstQ.push_back(iWord(thorIsaPkg::OP_LDW, 5'd13, 5'd0, 15'h0010));
		issueBurst();
		checkReg(13);
		checkStatus();
		writeInstr(rWord(7'h3C, 5'd13, 5'd1, 5'd2));
		checkReg(13);
		checkStatus();
	endtask

	task automatic busErrors();
		randomReady = 1'b1;
		expectWriteError(12'h008, iWord(thorIsaPkg::OP_ADDI, 5'd14, 5'd0, 15'h0FFF));
		expectWriteError(`THOR_ADDR_STATUS, 32'h0000_0001);
		expectWriteError(regAddr(14), 32'h1234_5678);
		checkRead(12'h008, 32'h0, thorBusPkg::RESP_SLVERR);
		checkRead(12'h07C, 32'h0, thorBusPkg::RESP_SLVERR);
		checkRead(12'h100, 32'h0, thorBusPkg::RESP_SLVERR);
		checkRead(12'hFFC, 32'h0, thorBusPkg::RESP_SLVERR);
		writeInstr(iWord(thorIsaPkg::OP_ADDI, 5'd15, 5'd0, 15'h2468));
		checkReg(14);
		checkReg(15);
		checkStatus();
		randomReady = 1'b0;
	endtask

	task automatic startTest();
		testErrors = errorCount;
		testCount++;
	endtask

	task automatic reportTest(input string name);
		if (errorCount == testErrors)
			$display("test %0d %s: ok", testCount, name);
		else
		begin
			$display("test %0d %s: FAIL with %0d errors", testCount, name,
				errorCount - testErrors);
			failedTests++;
		end
	endtask

	// ==========================================================================
	// Main sequence
	// ==========================================================================

	initial
	begin
		int i;
		void'($urandom(seed));
		req         = '0;
		rst         = 1'b1;
		refRetired  = 0;
		refIllegal  = 0;
		errorCount  = 0;
		testCount   = 0;
		failedTests = 0;
		cycleCount  = 0;
		randomReady = 1'b0;
		for (i = 0; i < `THOR_NREGS; i++)
			refRegs[i] = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		startTest();
		resetChecks();
		reportTest("reset state");
		startTest();
		registerOps();
		reportTest("register ALU forms");
		startTest();
		immediateOps();
		reportTest("immediate forms");
		startTest();
		dependentChain();
		reportTest("dependent chain");
		startTest();
		illegalOps();
		reportTest("illegal opcodes");
		startTest();
		busErrors();
		reportTest("bus errors and delayed ready");

		$display("%0d tests run, %0d failed, %0d check errors", testCount, failedTests,
			errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+design
design/thorIsaPkg.sv
design/thorBusPkg.sv
design/thorDecodeHasImm.sv
design/thorDecoder.sv
design/thorAlu.sv
design/thorRegfile.sv
design/thorAxiSlave.sv
design/thorExecUnit.sv
bench/thorExecUnitTb.sv

// ==== design/thorAlu.sv ====
// Execute stage that computes the ALU result and registers it with its destination
`timescale 1ns/1ps
`include "thorCore_params.svh"

module thorAlu
(
	input  logic                    clk,
	input  logic                    rst,
	input  thorIsaPkg::decoded_t    dec,
	output thorIsaPkg::execResult_t res
);

	logic [`THOR_XLEN-1:0] result;
	logic                  lessThan;

	// Signed compare for slt and slti
	assign lessThan = $signed(dec.a) < $signed(dec.b);

	// =========================================================================
	// Operation select
	// =========================================================================

	always_comb
	begin
		case (dec.aluOp)
		thorIsaPkg::ALU_ADD:
			result = dec.a + dec.b;
		thorIsaPkg::ALU_SUB:
			result = dec.a - dec.b;
		// Reverse subtract, so subfi gives the immediate minus the register
		thorIsaPkg::ALU_SUBF:
			result = dec.b - dec.a;
		thorIsaPkg::ALU_AND:
			result = dec.a & dec.b;
		thorIsaPkg::ALU_OR:
			result = dec.a | dec.b;
		thorIsaPkg::ALU_EOR:
			result = dec.a ^ dec.b;
		thorIsaPkg::ALU_SLT:
			result = {{(`THOR_XLEN-1){1'b0}}, lessThan};
		// Illegal instructions carry no operation and produce zero
		default:
			result = '0;
		endcase
	end

	// =========================================================================
	// Execute register
	// =========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			res.valid   <= 1'b0;
			res.illegal <= 1'b0;
			res.we      <= 1'b0;
		end
		else
		begin
			// Control bits pass through one cycle behind decode
			res.valid   <= dec.valid;
			res.illegal <= dec.illegal;
			res.we      <= dec.we;
			res.rd      <= dec.rd;
			res.result  <= result;
		end
	end

endmodule

// ==== design/thorAxiSlave.sv ====
// AXI4-Lite slave that issues written instruction words and returns register and status reads
`timescale 1ns/1ps
`include "thorCore_params.svh"

module thorAxiSlave
(
	input  logic                     clk,
	input  logic                     rst,
	input  thorBusPkg::axiReq_t      req,
	output thorBusPkg::axiRsp_t      rsp,
	input  logic                     busy,
	output logic                     issue,
	output thorIsaPkg::instruction_t instr,
	output logic [`THOR_REGW-1:0]    hostIdx,
	input  logic [`THOR_XLEN-1:0]    hostData,
	input  logic [`THOR_CNTW-1:0]    retired,
	input  logic [`THOR_CNTW-1:0]    illegal
);

	// Byte span of the register window
	localparam logic [`THOR_AXI_AW-1:0] WIN_BYTES = `THOR_AXI_AW'(`THOR_NREGS * 4);

	logic                    wrFire;
	logic                    rdFire;
	logic                    wrIsInstr;
	logic [`THOR_AXI_AW-1:0] regOff;
	logic                    inWindow;
	logic                    isStatus;
	logic [`THOR_XLEN-1:0]   rdDataSel;
	logic [1:0]              rdRespSel;
	logic                    bvalidQ;
	logic [1:0]              brespQ;
	logic                    rvalidQ;
	logic [`THOR_XLEN-1:0]   rdataQ;
	logic [1:0]              rrespQ;

	// =========================================================================
	// Handshakes
	// =========================================================================

	// Address and data are taken together, one write in flight at a time
	assign wrFire = req.awvalid && req.wvalid && !bvalidQ;
	// Reads wait until every issued instruction has retired, including one
	// that is being accepted in this very cycle
	assign rdFire = req.arvalid && !rvalidQ && !busy && !wrFire;

	assign wrIsInstr = (req.awaddr == `THOR_ADDR_INSTR);

	// =========================================================================
	// Read address decode
	// =========================================================================

	// Addresses below the base wrap to large offsets and fall outside
	assign regOff   = req.araddr - `THOR_ADDR_REGBASE;
	assign inWindow = (regOff < WIN_BYTES) && (regOff[1:0] == 2'b00);
	assign isStatus = (req.araddr == `THOR_ADDR_STATUS);
	assign hostIdx  = regOff[`THOR_REGW+1:2];

	always_comb
	begin
		rdDataSel = '0;
		rdRespSel = thorBusPkg::RESP_SLVERR;
		if (isStatus)
		begin
			// Illegal count in the upper half, retired count in the lower
			rdDataSel = {illegal, retired};
			rdRespSel = thorBusPkg::RESP_OKAY;
		end
		else if (inWindow)
		begin
			rdDataSel = hostData;
			rdRespSel = thorBusPkg::RESP_OKAY;
		end
	end

	// =========================================================================
	// Response state
	// =========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bvalidQ <= 1'b0;
			rvalidQ <= 1'b0;
			issue   <= 1'b0;
		end
		else
		begin
			// One cycle pulse per accepted instruction word
			issue <= wrFire && wrIsInstr;
			if (wrFire)
				bvalidQ <= 1'b1;
			else if (req.bready)
				bvalidQ <= 1'b0;
			if (rdFire)
				rvalidQ <= 1'b1;
			else if (req.rready)
				rvalidQ <= 1'b0;
		end
	end

	// Response payloads are captured at their handshake and then held
	always_ff @(posedge clk)
	begin
		if (wrFire)
		begin
			instr  <= thorIsaPkg::instruction_t'(req.wdata);
			brespQ <= wrIsInstr ? thorBusPkg::RESP_OKAY : thorBusPkg::RESP_SLVERR;
		end
		if (rdFire)
		begin
			rdataQ <= rdDataSel;
			rrespQ <= rdRespSel;
		end
	end

	always_comb
	begin
		rsp.awready = wrFire;
		rsp.wready  = wrFire;
		rsp.bvalid  = bvalidQ;
		rsp.bresp   = brespQ;
		rsp.arready = rdFire;
		rsp.rvalid  = rvalidQ;
		rsp.rdata   = rdataQ;
		rsp.rresp   = rrespQ;
	end

endmodule

// ==== design/thorBusPkg.sv ====
// Host bus types: AXI4-Lite request and response structs and the response codes
`include "thorCore_params.svh"

package thorBusPkg;

	// Response codes on bresp and rresp
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Everything the host drives, all five channels together
	typedef struct packed {
		logic                      awvalid;
		logic [`THOR_AXI_AW-1:0]   awaddr;
		logic                      wvalid;
		logic [`THOR_XLEN-1:0]     wdata;
		logic [`THOR_XLEN/8-1:0]   wstrb;
		logic                      bready;
		logic                      arvalid;
		logic [`THOR_AXI_AW-1:0]   araddr;
		logic                      rready;
	} axiReq_t;

	// Everything the slave drives back
	typedef struct packed {
		logic                  awready;
		logic                  wready;
		logic                  bvalid;
		logic [1:0]            bresp;
		logic                  arready;
		logic                  rvalid;
		logic [`THOR_XLEN-1:0] rdata;
		logic [1:0]            rresp;
	} axiRsp_t;

endpackage

// ==== design/thorCore_params.svh ====
// Thor execution slice constants for datapath widths, instruction fields and the host address map
`ifndef THOR_CORE_PARAMS_SVH
`define THOR_CORE_PARAMS_SVH

// =========================================================================
// Datapath
// =========================================================================

// Width of a general register and of every ALU operand
`define THOR_XLEN 32
// Size of the register file and the width of an index into it
`define THOR_NREGS 32
`define THOR_REGW 5
// Retired and illegal counters share the status word half and half
`define THOR_CNTW 16

// =========================================================================
// Instruction fields, packed from bit 0 upward
// =========================================================================

// Opcode sits in the low bits, then rd, ra, and rb or the immediate
`define THOR_OPCW 7
// Immediate covers bits 31:17, so it overlaps rb in its low five bits
`define THOR_IMMW 15
// Unused upper bits of a register form, above rb
`define THOR_FUNCTW 10

// =========================================================================
// Host port address map
// =========================================================================

`define THOR_AXI_AW 12
`define THOR_ADDR_INSTR 12'h000
`define THOR_ADDR_STATUS 12'h004
// Register window, one word per register
`define THOR_ADDR_REGBASE 12'h080

`endif

// ==== design/thorDecodeHasImm.sv ====
// Immediate detector that flags opcodes taking their second operand from the immediate field
`timescale 1ns/1ps

module thorDecodeHasImm
(
	input  thorIsaPkg::instruction_t instr,
	output logic                     hasImm
);

	// The opcode bits are common to both instruction views
	always_comb
	begin
		case (instr.i.opcode)
		// Arithmetic and logic immediates
		thorIsaPkg::OP_ADDI, thorIsaPkg::OP_SUBFI, thorIsaPkg::OP_ANDI,
		thorIsaPkg::OP_ORI, thorIsaPkg::OP_EORI, thorIsaPkg::OP_SLTI:
			hasImm = 1'b1;
		// Return carries its deallocation amount as an immediate
		thorIsaPkg::OP_RTD:
			hasImm = 1'b1;
		// Memory and cache forms use the immediate as a displacement
		thorIsaPkg::OP_LDB, thorIsaPkg::OP_LDBU, thorIsaPkg::OP_LDW,
		thorIsaPkg::OP_LDWU, thorIsaPkg::OP_LDT, thorIsaPkg::OP_LDTU,
		thorIsaPkg::OP_LDO, thorIsaPkg::OP_LDA, thorIsaPkg::OP_CACHE,
		thorIsaPkg::OP_STB, thorIsaPkg::OP_STW, thorIsaPkg::OP_STT,
		thorIsaPkg::OP_STO:
			hasImm = 1'b1;
		default:
			hasImm = 1'b0;
		endcase
	end

endmodule

// ==== design/thorDecoder.sv ====
// Decode stage that selects the ALU operation and reads forwarded operands into a register
`timescale 1ns/1ps
`include "thorCore_params.svh"

module thorDecoder
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     issue,
	input  thorIsaPkg::instruction_t instr,
	output logic [`THOR_REGW-1:0]    rdA,
	output logic [`THOR_REGW-1:0]    rdB,
	input  logic [`THOR_XLEN-1:0]    rfDataA,
	input  logic [`THOR_XLEN-1:0]    rfDataB,
	input  thorIsaPkg::execResult_t  exFwd,
	input  thorIsaPkg::execResult_t  wbFwd,
	output thorIsaPkg::decoded_t     dec
);

	logic                  hasImm;
	logic                  legal;
	thorIsaPkg::aluOp_t    aluOp;
	logic [`THOR_XLEN-1:0] immExt;
	logic [`THOR_XLEN-1:0] opA;
	logic [`THOR_XLEN-1:0] regB;

	// Register zero reads zero, then the youngest in-flight result wins
	function automatic logic [`THOR_XLEN-1:0] fnOperand(
		input logic [`THOR_REGW-1:0] idx,
		input logic [`THOR_XLEN-1:0] fileData,
		input thorIsaPkg::execResult_t ex,
		input thorIsaPkg::execResult_t wb
	);
		if (idx == '0)
			return '0;
		if (ex.valid && ex.we && ex.rd == idx)
			return ex.result;
		if (wb.valid && wb.we && wb.rd == idx)
			return wb.result;
		return fileData;
	endfunction

	thorDecodeHasImm hasImm_i
	(
		.instr  (instr),
		.hasImm (hasImm)
	);

	// Opcode to ALU operation, anything unlisted is illegal
	always_comb
	begin
		legal = 1'b1;
		aluOp = thorIsaPkg::ALU_NONE;
		case (instr.r.opcode)
		thorIsaPkg::OP_ADD, thorIsaPkg::OP_ADDI:  aluOp = thorIsaPkg::ALU_ADD;
		thorIsaPkg::OP_SUB:                       aluOp = thorIsaPkg::ALU_SUB;
		thorIsaPkg::OP_SUBFI:                     aluOp = thorIsaPkg::ALU_SUBF;
		thorIsaPkg::OP_AND, thorIsaPkg::OP_ANDI:  aluOp = thorIsaPkg::ALU_AND;
		thorIsaPkg::OP_OR, thorIsaPkg::OP_ORI:    aluOp = thorIsaPkg::ALU_OR;
		thorIsaPkg::OP_EOR, thorIsaPkg::OP_EORI:  aluOp = thorIsaPkg::ALU_EOR;
		thorIsaPkg::OP_SLT, thorIsaPkg::OP_SLTI:  aluOp = thorIsaPkg::ALU_SLT;
		default:                                  legal = 1'b0;
		endcase
	end

	// Register file read addresses come straight from the word
	assign rdA = instr.r.ra;
	assign rdB = instr.r.rb;

	// Sign-extend the 15-bit field to the full width
	assign immExt = {{(`THOR_XLEN-`THOR_IMMW){instr.i.imm[`THOR_IMMW-1]}}, instr.i.imm};

	assign opA  = fnOperand(instr.r.ra, rfDataA, exFwd, wbFwd);
	assign regB = fnOperand(instr.r.rb, rfDataB, exFwd, wbFwd);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dec.valid   <= 1'b0;
			dec.illegal <= 1'b0;
			dec.we      <= 1'b0;
		end
		else
		begin
			dec.valid   <= issue;
			dec.illegal <= issue && !legal;
			// Writes to r0 are dropped here so later stages never see them
			dec.we      <= issue && legal && (instr.r.rd != '0);
			dec.rd      <= instr.r.rd;
			dec.aluOp   <= aluOp;
			dec.a       <= opA;
			dec.b       <= hasImm ? immExt : regB;
		end
	end

endmodule

// ==== design/thorExecUnit.sv ====
// Top of the execution slice joining the host slave, decode, execute and result stages
`timescale 1ns/1ps
`include "thorCore_params.svh"

module thorExecUnit
(
	input  logic                clk,
	input  logic                rst,
	input  thorBusPkg::axiReq_t req,
	output thorBusPkg::axiRsp_t rsp
);

	logic                     issue;
	thorIsaPkg::instruction_t instr;
	logic                     busy;
	logic [`THOR_REGW-1:0]    rdA;
	logic [`THOR_REGW-1:0]    rdB;
	logic [`THOR_REGW-1:0]    hostIdx;
	logic [`THOR_XLEN-1:0]    rfDataA;
	logic [`THOR_XLEN-1:0]    rfDataB;
	logic [`THOR_XLEN-1:0]    hostData;
	logic [`THOR_CNTW-1:0]    retired;
	logic [`THOR_CNTW-1:0]    illegal;
	thorIsaPkg::decoded_t     dec;
	thorIsaPkg::execResult_t  aluRes;

	// Something is in flight while any stage holds a valid instruction
	assign busy = issue | dec.valid | aluRes.valid;

	thorAxiSlave slave_i
	(
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.rsp      (rsp),
		.busy     (busy),
		.issue    (issue),
		.instr    (instr),
		.hostIdx  (hostIdx),
		.hostData (hostData),
		.retired  (retired),
		.illegal  (illegal)
	);

	// The register file writes straight from the execute register, so its
	// write port and the execute result are the same struct
	thorDecoder decoder_i
	(
		.clk     (clk),
		.rst     (rst),
		.issue   (issue),
		.instr   (instr),
		.rdA     (rdA),
		.rdB     (rdB),
		.rfDataA (rfDataA),
		.rfDataB (rfDataB),
		.exFwd   (aluRes),
		.wbFwd   (aluRes),
		.dec     (dec)
	);

	thorAlu alu_i
	(
		.clk (clk),
		.rst (rst),
		.dec (dec),
		.res (aluRes)
	);

	thorRegfile regfile_i
	(
		.clk      (clk),
		.rst      (rst),
		.res      (aluRes),
		.rdA      (rdA),
		.rdB      (rdB),
		.hostIdx  (hostIdx),
		.rfDataA  (rfDataA),
		.rfDataB  (rfDataB),
		.hostData (hostData),
		.retired  (retired),
		.illegal  (illegal)
	);

endmodule

// ==== design/thorIsaPkg.sv ====
// Thor instruction set types: opcodes, instruction word layouts, decoded and executed forms
`include "thorCore_params.svh"

package thorIsaPkg;

	// =========================================================================
	// Opcodes
	// =========================================================================

	// Register and immediate ALU forms are kept by the slice
	// The memory, cache and return opcodes are named only for immediate detection
	typedef enum logic [`THOR_OPCW-1:0]
	{
		OP_ADDI  = 7'h04,
		OP_SUBFI = 7'h05,
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_EORI  = 7'h0A,
		OP_SLTI  = 7'h0B,
		OP_ADD   = 7'h10,
		OP_SUB   = 7'h11,
		OP_AND   = 7'h12,
		OP_OR    = 7'h13,
		OP_EOR   = 7'h14,
		OP_SLT   = 7'h15,
		OP_RTD   = 7'h1B,
		OP_LDB   = 7'h40,
		OP_LDBU  = 7'h41,
		OP_LDW   = 7'h42,
		OP_LDWU  = 7'h43,
		OP_LDT   = 7'h44,
		OP_LDTU  = 7'h45,
		OP_LDO   = 7'h46,
		OP_LDA   = 7'h4A,
		OP_CACHE = 7'h4F,
		OP_STB   = 7'h50,
		OP_STW   = 7'h51,
		OP_STT   = 7'h52,
		OP_STO   = 7'h53
	} opcode_t;

	// Register form, with rb in bits 21:17
	typedef struct packed {
		logic [`THOR_FUNCTW-1:0] funct;
		logic [`THOR_REGW-1:0]   rb;
		logic [`THOR_REGW-1:0]   ra;
		logic [`THOR_REGW-1:0]   rd;
		opcode_t                 opcode;
	} rForm_t;

	// Immediate form, the 15-bit immediate fills bits 31:17
	typedef struct packed {
		logic [`THOR_IMMW-1:0] imm;
		logic [`THOR_REGW-1:0] ra;
		logic [`THOR_REGW-1:0] rd;
		opcode_t               opcode;
	} iForm_t;

	// Both views describe the same 32-bit word
	typedef union packed {
		rForm_t r;
		iForm_t i;
	} instruction_t;

	// =========================================================================
	// Pipeline payloads
	// =========================================================================

	// subFrom computes operand B minus operand A, for subfi
	typedef enum logic [2:0]
	{
		ALU_ADD, ALU_SUB, ALU_SUBF, ALU_AND, ALU_OR, ALU_EOR, ALU_SLT, ALU_NONE
	} aluOp_t;

	// Decode to execute
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		logic                  we;
		logic [`THOR_REGW-1:0] rd;
		aluOp_t                aluOp;
		logic [`THOR_XLEN-1:0] a;
		logic [`THOR_XLEN-1:0] b;
	} decoded_t;

	// Execute to result stage, also the forwarding source
	typedef struct packed {
		logic                  valid;
		logic                  illegal;
		logic                  we;
		logic [`THOR_REGW-1:0] rd;
		logic [`THOR_XLEN-1:0] result;
	} execResult_t;

endpackage

// ==== design/thorRegfile.sv ====
// Result stage holding the register file and the retired and illegal instruction counters
`timescale 1ns/1ps
`include "thorCore_params.svh"

module thorRegfile
(
	input  logic                    clk,
	input  logic                    rst,
	input  thorIsaPkg::execResult_t res,
	input  logic [`THOR_REGW-1:0]   rdA,
	input  logic [`THOR_REGW-1:0]   rdB,
	input  logic [`THOR_REGW-1:0]   hostIdx,
	output logic [`THOR_XLEN-1:0]   rfDataA,
	output logic [`THOR_XLEN-1:0]   rfDataB,
	output logic [`THOR_XLEN-1:0]   hostData,
	output logic [`THOR_CNTW-1:0]   retired,
	output logic [`THOR_CNTW-1:0]   illegal
);

	logic [`THOR_XLEN-1:0] regs [`THOR_NREGS];

	// Every register reads zero after reset
	// Decode already cleared write-enable for r0, so entry zero is never written
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `THOR_NREGS; i++)
				regs[i] <= '0;
		end
		else if (res.valid && res.we)
			regs[res.rd] <= res.result;
	end

	// Every result retires, illegal ones are also counted on their own
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			retired <= '0;
			illegal <= '0;
		end
		else if (res.valid)
		begin
			retired <= retired + 1'b1;
			if (res.illegal)
				illegal <= illegal + 1'b1;
		end
	end

	// Asynchronous reads, r0 is forced to zero on every port
	assign rfDataA  = (rdA == '0) ? '0 : regs[rdA];
	assign rfDataB  = (rdB == '0) ? '0 : regs[rdB];
	assign hostData = (hostIdx == '0) ? '0 : regs[hostIdx];

endmodule
